/* logic/wb_pkg.sv */
package wb_pkg;

  // bus widths
  localparam int ADR_W = 32;
  localparam int DAT_W = 32;
  localparam int SEL_W = DAT_W / 8;  // one select per byte lane

  // on-chip memory, word addressed by adr[11:2]
  localparam int RAM_AW    = 10;
  localparam int RAM_WORDS = 1 << RAM_AW;

  // built-in self-test script
  localparam int SCRIPT_LEN = 24;
  localparam int SCRIPT_AW  = 5;

  // cycle type identifier
  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_INC     = 3'b010,  // incrementing burst, more beats follow
    CTI_EOB     = 3'b111   // last beat of a burst
  } cti_t;

  // burst type extension, only meaningful with CTI_INC
  typedef enum logic [1:0] {
    BTE_LINEAR = 2'b00,
    BTE_WRAP4  = 2'b01,
    BTE_WRAP8  = 2'b10,
    BTE_WRAP16 = 2'b11
  } bte_t;

endpackage

/* logic/wb_cycle_rom.sv */
module wb_cycle_rom (
  input  logic [wb_pkg::SCRIPT_AW-1:0] index_i,
  output logic [wb_pkg::ADR_W-1:0]     adr_o,
  output wb_pkg::bte_t                 bte_o,
  output wb_pkg::cti_t                 cti_o,
  output logic [wb_pkg::DAT_W-1:0]     dat_o,
  output logic [wb_pkg::SEL_W-1:0]     sel_o,
  output logic                         we_o,
  output logic                         cyc_o,
  output logic                         stb_o,
  output logic [wb_pkg::DAT_W-1:0]     exp_o
);
  import wb_pkg::*;

  // {adr, bte, cti, dat, sel, {we, cyc, stb}, expected read data}
  logic [ADR_W+$bits(bte_t)+$bits(cti_t)+DAT_W+SEL_W+3+DAT_W-1:0] row;
  logic [$bits(bte_t)-1:0] bte_bits;
  logic [$bits(cti_t)-1:0] cti_bits;

  // idle entries hold cyc with stb low, so the port is not given away mid script
  always_comb begin
    case (index_i)
      // single word write, then read it back
      1:  row = {32'h100, BTE_LINEAR, CTI_CLASSIC, 32'h1234_5678, 4'hf, 3'b111, 32'h0};
      2:  row = {32'h100, BTE_LINEAR, CTI_CLASSIC, 32'h0, 4'hf, 3'b011, 32'h1234_5678};

      // wrap-4 write burst at 0x200
      4:  row = {32'h200, BTE_WRAP4, CTI_INC, 32'h0001_0002, 4'hf, 3'b111, 32'h0};
      5:  row = {32'h204, BTE_WRAP4, CTI_INC, 32'h0003_0004, 4'hf, 3'b111, 32'h0};
      6:  row = {32'h208, BTE_WRAP4, CTI_INC, 32'h0005_0006, 4'hf, 3'b111, 32'h0};
      7:  row = {32'h20c, BTE_WRAP4, CTI_EOB, 32'h0007_0008, 4'hf, 3'b111, 32'h0};

      8:  row = {32'h208, BTE_LINEAR, CTI_CLASSIC, 32'ha1ff_ffff, 4'h8, 3'b111, 32'h0};

      // read the burst back, top byte of 0x208 now patched
      9:  row = {32'h200, BTE_WRAP4, CTI_INC, 32'h0, 4'hf, 3'b011, 32'h0001_0002};
      10: row = {32'h204, BTE_WRAP4, CTI_INC, 32'h0, 4'hf, 3'b011, 32'h0003_0004};
      11: row = {32'h208, BTE_WRAP4, CTI_INC, 32'h0, 4'hf, 3'b011, 32'ha105_0006};
      12: row = {32'h20c, BTE_WRAP4, CTI_EOB, 32'h0, 4'hf, 3'b011, 32'h0007_0008};

      // linear pair at 0x300
      13: row = {32'h300, BTE_LINEAR, CTI_INC, 32'hdead_dead, 4'hf, 3'b111, 32'h0};
      14: row = {32'h304, BTE_LINEAR, CTI_EOB, 32'h5555_5555, 4'hf, 3'b111, 32'h0};
      15: row = {32'h300, BTE_LINEAR, CTI_INC, 32'h0, 4'hf, 3'b011, 32'hdead_dead};
      16: row = {32'h304, BTE_LINEAR, CTI_EOB, 32'h0, 4'hf, 3'b011, 32'h5555_5555};

      // wrap-4 read entering mid block, rolls over to 0x200
      17: row = {32'h208, BTE_WRAP4, CTI_INC, 32'h0, 4'hf, 3'b011, 32'ha105_0006};
      18: row = {32'h20c, BTE_WRAP4, CTI_INC, 32'h0, 4'hf, 3'b011, 32'h0007_0008};
      19: row = {32'h200, BTE_WRAP4, CTI_INC, 32'h0, 4'hf, 3'b011, 32'h0001_0002};
      20: row = {32'h204, BTE_WRAP4, CTI_EOB, 32'h0, 4'hf, 3'b011, 32'h0003_0004};

      default: row = {32'h0, BTE_LINEAR, CTI_CLASSIC, 32'h0, 4'h0, 3'b010, 32'h0};
    endcase
  end

  assign {adr_o, bte_bits, cti_bits, dat_o, sel_o, we_o, cyc_o, stb_o, exp_o} = row;

  assign bte_o = bte_t'(bte_bits);
  assign cti_o = cti_t'(cti_bits);

endmodule

/* logic/wb_script_master.sv */
module wb_script_master (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start_i,
  output logic [wb_pkg::SCRIPT_AW-1:0] index_o,
  input  logic [wb_pkg::ADR_W-1:0]     rom_adr_i,
  input  wb_pkg::bte_t                 rom_bte_i,
  input  wb_pkg::cti_t                 rom_cti_i,
  input  logic [wb_pkg::DAT_W-1:0]     rom_dat_i,
  input  logic [wb_pkg::SEL_W-1:0]     rom_sel_i,
  input  logic                         rom_we_i,
  input  logic                         rom_cyc_i,
  input  logic                         rom_stb_i,
  input  logic [wb_pkg::DAT_W-1:0]     rom_exp_i,
  output logic                         m_cyc_o,
  output logic                         m_stb_o,
  output logic                         m_we_o,
  output logic [wb_pkg::ADR_W-1:0]     m_adr_o,
  output logic [wb_pkg::SEL_W-1:0]     m_sel_o,
  output logic [wb_pkg::DAT_W-1:0]     m_dat_o,
  output wb_pkg::cti_t                 m_cti_o,
  output wb_pkg::bte_t                 m_bte_o,
  input  logic [wb_pkg::DAT_W-1:0]     m_dat_i,
  input  logic                         m_ack_i,
  output logic                         done_o,
  output logic                         pass_o,
  output logic                         busy_o
);
  import wb_pkg::*;

  logic                 run_q;
  logic                 done_q;
  logic                 fail_q;  // sticky read mismatch
  logic [SCRIPT_AW-1:0] idx_q;
  logic                 beat_done;
  logic                 step;
  logic                 last;
  logic                 rd_bad;

  // entry goes out as is, only cyc and stb wait for the run flag
  assign m_cyc_o = run_q & rom_cyc_i;
  assign m_stb_o = run_q & rom_stb_i;
  assign m_we_o  = rom_we_i;
  assign m_adr_o = rom_adr_i;
  assign m_sel_o = rom_sel_i;
  assign m_dat_o = rom_dat_i;
  assign m_cti_o = rom_cti_i;
  assign m_bte_o = rom_bte_i;

  assign beat_done = m_cyc_o & m_stb_o & m_ack_i;
  assign step      = run_q & (beat_done | ~(rom_cyc_i & rom_stb_i));  // no strobe, move on
  assign last      = (idx_q == SCRIPT_AW'(SCRIPT_LEN - 1));
  assign rd_bad    = beat_done & ~rom_we_i & (m_dat_i != rom_exp_i);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      fail_q <= 1'b0;
      idx_q  <= '0;
    end else if (!run_q) begin
      if (start_i) begin  // rerun clears the previous verdict
        run_q  <= 1'b1;
        done_q <= 1'b0;
        fail_q <= 1'b0;
        idx_q  <= '0;
      end
    end else begin
      if (rd_bad)
        fail_q <= 1'b1;
      if (step) begin
        if (last) begin
          run_q  <= 1'b0;
          done_q <= 1'b1;
        end else begin
          idx_q <= idx_q + SCRIPT_AW'(1);
        end
      end
    end
  end

  assign index_o = idx_q;
  assign done_o  = done_q;
  assign pass_o  = done_q & ~fail_q;
  assign busy_o  = run_q;

endmodule

/* logic/wb_burst_addr.sv */
module wb_burst_addr (
  input  logic [wb_pkg::RAM_AW-1:0] cur_adr_i,
  input  wb_pkg::bte_t              bte_i,
  output logic [wb_pkg::RAM_AW-1:0] next_adr_o
);
  import wb_pkg::*;

  logic [RAM_AW-1:0] inc_adr;
  logic [RAM_AW-1:0] wrap_mask;  // bits allowed to roll over

  assign inc_adr = cur_adr_i + RAM_AW'(1);

  // wrap bursts stay inside an aligned block of 4, 8 or 16 words
  always_comb begin
    case (bte_i)
      BTE_WRAP4:  wrap_mask = RAM_AW'(4'h3);
      BTE_WRAP8:  wrap_mask = RAM_AW'(4'h7);
      BTE_WRAP16: wrap_mask = RAM_AW'(4'hf);
      default:    wrap_mask = '1;  // linear
    endcase
  end

  // upper bits frozen, lower bits take the incremented value
  assign next_adr_o = (cur_adr_i & ~wrap_mask) | (inc_adr & wrap_mask);

endmodule

/* logic/wb_slave_ctrl.sv */
module wb_slave_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      m_cyc_i,
  input  logic                      m_stb_i,
  input  logic                      m_we_i,
  input  logic [wb_pkg::ADR_W-1:0]  m_adr_i,
  input  logic [wb_pkg::SEL_W-1:0]  m_sel_i,
  input  logic [wb_pkg::DAT_W-1:0]  m_dat_i,
  input  wb_pkg::cti_t              m_cti_i,
  input  wb_pkg::bte_t              m_bte_i,
  output logic                      m_ack_o,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [wb_pkg::ADR_W-1:0]  wb_adr_i,
  input  logic [wb_pkg::SEL_W-1:0]  wb_sel_i,
  input  logic [wb_pkg::DAT_W-1:0]  wb_dat_i,
  input  wb_pkg::cti_t              wb_cti_i,
  input  wb_pkg::bte_t              wb_bte_i,
  output logic                      wb_ack_o,
  input  logic [wb_pkg::RAM_AW-1:0] next_adr_i,
  output logic [wb_pkg::RAM_AW-1:0] cur_adr_o,
  output wb_pkg::bte_t              cur_bte_o,
  output logic [wb_pkg::RAM_AW-1:0] ram_addr_o,
  output logic                      ram_we_o,
  output logic [wb_pkg::SEL_W-1:0]  ram_be_o,
  output logic [wb_pkg::DAT_W-1:0]  ram_wdata_o
);
  import wb_pkg::*;

  logic             grant_q;    // high while the script port owns the RAM
  logic             ack_q;
  logic             burst_act;  // INC beat completing, next beat already due
  logic             beat_done;
  logic             g_cyc;
  logic             g_stb;
  logic             g_we;
  logic [ADR_W-1:0] g_adr;
  logic [SEL_W-1:0] g_sel;
  logic [DAT_W-1:0] g_dat;
  cti_t             g_cti;
  bte_t             g_bte;

  // granted port view
  always_comb begin
    g_cyc = grant_q ? m_cyc_i : wb_cyc_i;
    g_stb = grant_q ? m_stb_i : wb_stb_i;
    g_we  = grant_q ? m_we_i  : wb_we_i;
    g_adr = grant_q ? m_adr_i : wb_adr_i;
    g_sel = grant_q ? m_sel_i : wb_sel_i;
    g_dat = grant_q ? m_dat_i : wb_dat_i;
    g_cti = grant_q ? m_cti_i : wb_cti_i;
    g_bte = grant_q ? m_bte_i : wb_bte_i;
  end

  assign beat_done = g_cyc & g_stb & ack_q;
  assign burst_act = beat_done & (g_cti == CTI_INC);

  // port only changes hands once its owner has let go of cyc
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      grant_q <= 1'b0;
    else if (!g_cyc)
      grant_q <= m_cyc_i;  // script first
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      ack_q <= 1'b0;
    else if (!g_cyc)
      ack_q <= 1'b0;
    else if (beat_done)
      ack_q <= burst_act;  // classic and EOB beats take a gap
    else
      ack_q <= g_stb;  // new request, or stb dropped mid burst
  end

  assign m_ack_o  = ack_q & grant_q;
  assign wb_ack_o = ack_q & ~grant_q;

  assign cur_adr_o = g_adr[RAM_AW+1:2];
  assign cur_bte_o = g_bte;

  // read ahead at the predicted word while a read burst keeps going
  assign ram_addr_o  = (burst_act && !g_we) ? next_adr_i : g_adr[RAM_AW+1:2];
  assign ram_we_o    = beat_done & g_we;
  assign ram_be_o    = g_sel;
  assign ram_wdata_o = g_dat;

endmodule

/* logic/wb_byte_ram.sv */
module wb_byte_ram (
  input  logic                      clk,
  input  logic [wb_pkg::RAM_AW-1:0] addr_i,
  input  logic                      we_i,
  input  logic [wb_pkg::SEL_W-1:0]  be_i,
  input  logic [wb_pkg::DAT_W-1:0]  wdata_i,
  output logic [wb_pkg::DAT_W-1:0]  rdata_o
);
  import wb_pkg::*;

  logic [DAT_W-1:0] mem [RAM_WORDS];

  // read before write on the same address
  always_ff @(posedge clk) begin
    for (int b = 0; b < SEL_W; b++) begin
      if (we_i && be_i[b])
        mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];  // byte lane b
    end
    rdata_o <= mem[addr_i];
  end

endmodule

/* logic/wb_mem_top.sv */
module wb_mem_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start_i,
  output logic                     done_o,
  output logic                     pass_o,
  output logic                     busy_o,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [wb_pkg::ADR_W-1:0] wb_adr_i,
  input  logic [wb_pkg::SEL_W-1:0] wb_sel_i,
  input  logic [wb_pkg::DAT_W-1:0] wb_dat_i,
  input  wb_pkg::cti_t             wb_cti_i,
  input  wb_pkg::bte_t             wb_bte_i,
  output logic [wb_pkg::DAT_W-1:0] wb_dat_o,
  output logic                     wb_ack_o
);
  import wb_pkg::*;

  // script ROM entry
  logic [SCRIPT_AW-1:0] index;
  logic [ADR_W-1:0]     rom_adr;
  bte_t                 rom_bte;
  cti_t                 rom_cti;
  logic [DAT_W-1:0]     rom_dat;
  logic [SEL_W-1:0]     rom_sel;
  logic                 rom_we;
  logic                 rom_cyc;
  logic                 rom_stb;
  logic [DAT_W-1:0]     rom_exp;

  // internal master bus
  logic                 m_cyc;
  logic                 m_stb;
  logic                 m_we;
  logic [ADR_W-1:0]     m_adr;
  logic [SEL_W-1:0]     m_sel;
  logic [DAT_W-1:0]     m_dat;
  cti_t                 m_cti;
  bte_t                 m_bte;
  logic                 m_ack;

  // controller to predictor and RAM
  logic [RAM_AW-1:0]    cur_adr;
  bte_t                 cur_bte;
  logic [RAM_AW-1:0]    next_adr;
  logic [RAM_AW-1:0]    ram_addr;
  logic                 ram_we;
  logic [SEL_W-1:0]     ram_be;
  logic [DAT_W-1:0]     ram_wdata;

  wb_cycle_rom rom0 (
    .index_i(index),
    .adr_o  (rom_adr),
    .bte_o  (rom_bte),
    .cti_o  (rom_cti),
    .dat_o  (rom_dat),
    .sel_o  (rom_sel),
    .we_o   (rom_we),
    .cyc_o  (rom_cyc),
    .stb_o  (rom_stb),
    .exp_o  (rom_exp)
  );

  wb_script_master mst0 (
    .clk      (clk),
    .reset    (reset),
    .start_i  (start_i),
    .index_o  (index),
    .rom_adr_i(rom_adr),
    .rom_bte_i(rom_bte),
    .rom_cti_i(rom_cti),
    .rom_dat_i(rom_dat),
    .rom_sel_i(rom_sel),
    .rom_we_i (rom_we),
    .rom_cyc_i(rom_cyc),
    .rom_stb_i(rom_stb),
    .rom_exp_i(rom_exp),
    .m_cyc_o  (m_cyc),
    .m_stb_o  (m_stb),
    .m_we_o   (m_we),
    .m_adr_o  (m_adr),
    .m_sel_o  (m_sel),
    .m_dat_o  (m_dat),
    .m_cti_o  (m_cti),
    .m_bte_o  (m_bte),
    .m_dat_i  (wb_dat_o),  // shared RAM read data
    .m_ack_i  (m_ack),
    .done_o   (done_o),
    .pass_o   (pass_o),
    .busy_o   (busy_o)
  );

  wb_slave_ctrl ctl0 (
    .clk        (clk),
    .reset      (reset),
    .m_cyc_i    (m_cyc),
    .m_stb_i    (m_stb),
    .m_we_i     (m_we),
    .m_adr_i    (m_adr),
    .m_sel_i    (m_sel),
    .m_dat_i    (m_dat),
    .m_cti_i    (m_cti),
    .m_bte_i    (m_bte),
    .m_ack_o    (m_ack),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_sel_i   (wb_sel_i),
    .wb_dat_i   (wb_dat_i),
    .wb_cti_i   (wb_cti_i),
    .wb_bte_i   (wb_bte_i),
    .wb_ack_o   (wb_ack_o),
    .next_adr_i (next_adr),
    .cur_adr_o  (cur_adr),
    .cur_bte_o  (cur_bte),
    .ram_addr_o (ram_addr),
    .ram_we_o   (ram_we),
    .ram_be_o   (ram_be),
    .ram_wdata_o(ram_wdata)
  );

  wb_burst_addr nxt0 (
    .cur_adr_i (cur_adr),
    .bte_i     (cur_bte),
    .next_adr_o(next_adr)
  );

  wb_byte_ram ram0 (
    .clk    (clk),
    .addr_i (ram_addr),
    .we_i   (ram_we),
    .be_i   (ram_be),
    .wdata_i(ram_wdata),
    .rdata_o(wb_dat_o)
  );

endmodule

/* tests/tb_checker.sv */
module tb_checker (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start_i,
  input  logic                     done_i,
  input  logic                     pass_i,
  input  logic                     busy_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [wb_pkg::ADR_W-1:0] wb_adr_i,
  input  logic [wb_pkg::SEL_W-1:0] wb_sel_i,
  input  logic [wb_pkg::DAT_W-1:0] wb_wdat_i,
  input  wb_pkg::cti_t             wb_cti_i,
  input  wb_pkg::bte_t             wb_bte_i,
  input  logic [wb_pkg::DAT_W-1:0] wb_rdat_i,
  input  logic                     wb_ack_i,
  output int                       checks_o,
  output int                       errors_o
);
  import wb_pkg::*;

  logic [DAT_W-1:0]  model [RAM_WORDS];
  logic              known [RAM_WORDS];  // word fully written at least once
  logic [RAM_AW-1:0] burst_start;
  int                beat_idx = 0;
  int                n_checks = 0;
  int                n_errors = 0;
  logic              prev_reset = 1'b0;
  logic              prev_start = 1'b0;
  logic              prev_done = 1'b0;
  logic              gap_due = 1'b0;   // last beat of a cycle was just acked
  logic              next_due = 1'b0;  // burst goes on, ack must follow at once

  assign checks_o = n_checks;
  assign errors_o = n_errors;

  initial begin
    int w;
    for (w = 0; w < RAM_WORDS; w++)
      known[w] = 1'b0;
  end

  function automatic logic [DAT_W-1:0] merge_bytes(input logic [DAT_W-1:0] old_w,
                                                   input logic [DAT_W-1:0] new_w,
                                                   input logic [SEL_W-1:0] sel);
    logic [DAT_W-1:0] res;
    int b;
    res = old_w;
    for (b = 0; b < SEL_W; b++)
      if (sel[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    return res;
  endfunction

  // word address of beat n, counted from the first beat of the burst
  function automatic logic [RAM_AW-1:0] wrap_word(input logic [RAM_AW-1:0] start,
                                                  input bte_t bte, input int beat);
    int len;
    int base;
    case (bte)
      BTE_WRAP4:  len = 4;
      BTE_WRAP8:  len = 8;
      BTE_WRAP16: len = 16;
      default:    len = 0;
    endcase
    if (len == 0)
      return start + RAM_AW'(beat);
    base = int'(start) - int'(start) % len;  // aligned block
    return RAM_AW'(base + (int'(start) - base + beat) % len);
  endfunction

  task automatic check_that(input logic ok, input string msg);
    n_checks++;
    if (!ok) begin
      n_errors++;
      $display("FAIL %0t: %s", $time, msg);
    end
  endtask

  task automatic compare_beat();
    logic [RAM_AW-1:0] word;
    logic [RAM_AW-1:0] exp_word;  // where the beat should read from
    word     = wb_adr_i[RAM_AW+1:2];
    exp_word = word;
    if (wb_cti_i != CTI_CLASSIC) begin
      if (beat_idx == 0)
        burst_start = word;
      exp_word = wrap_word(burst_start, wb_bte_i, beat_idx);
    end
    if (wb_we_i) begin
      model[word] = merge_bytes(model[word], wb_wdat_i, wb_sel_i);
      known[word] = known[word] | (wb_sel_i == '1);
    end else begin
      check_that(known[exp_word],
                 $sformatf("read of word %h that was never written", exp_word));
      check_that(wb_rdat_i === model[exp_word],
                 $sformatf("read %h at word %h, expected %h",
                           wb_rdat_i, exp_word, model[exp_word]));
    end
    if (wb_cti_i == CTI_INC) begin
      next_due = 1'b1;
      beat_idx++;
    end else begin  // classic or end of burst
      gap_due  = 1'b1;
      beat_idx = 0;
    end
  endtask

  always @(posedge clk) begin
    if (!reset) begin
      if (prev_reset)
        check_that(!wb_ack_i && !done_i && !pass_i && !busy_i, "outputs not low after reset");
      if (prev_start)
        check_that(busy_i, "busy_o did not rise after start_i");
      if (done_i && !prev_done)
        check_that(pass_i && !busy_i, "self-test done without pass");
      if (gap_due)
        check_that(!wb_ack_i, "ack held longer than one cycle");
      if (next_due && wb_stb_i)
        check_that(wb_ack_i, "missing ack inside burst");
      if (wb_ack_i)
        check_that(!busy_i, "external port acked while self-test busy");
      gap_due  = 1'b0;
      next_due = 1'b0;
      if (wb_cyc_i && wb_stb_i && wb_ack_i)
        compare_beat();
    end
    prev_reset = reset;
    prev_start = start_i && !busy_i && !reset;  // start is taken only while idle
    prev_done  = done_i;
  end

endmodule

/* tests/tb_top.sv */
module tb_top;
  import wb_pkg::*;

  localparam int DLY       = 10;  // drive delay after the rising edge
  localparam int N_WORDS   = 16;
  localparam int LIN_LEN   = 8;
  localparam int EXT_BEATS = 3 * N_WORDS + 2 * LIN_LEN + 16 + 4 + 8 + 16 + 1;
  localparam int WATCHDOG_CYCLES = 2 * SCRIPT_LEN * 40 + EXT_BEATS * 20;

  logic             clk;
  logic             reset;
  logic             start_i;
  logic             done_o;
  logic             pass_o;
  logic             busy_o;
  logic             wb_cyc_i;
  logic             wb_stb_i;
  logic             wb_we_i;
  logic [ADR_W-1:0] wb_adr_i;
  logic [SEL_W-1:0] wb_sel_i;
  logic [DAT_W-1:0] wb_dat_i;
  cti_t             wb_cti_i;
  bte_t             wb_bte_i;
  logic [DAT_W-1:0] wb_dat_o;
  logic             wb_ack_o;
  integer           seed;
  int               checks;
  int               errors;
  int               test_no = 0;
  int               err_mark = 0;

  wb_mem_top dut0 (.*);

  tb_checker chk0 (
    .clk      (clk),
    .reset    (reset),
    .start_i  (start_i),
    .done_i   (done_o),
    .pass_i   (pass_o),
    .busy_i   (busy_o),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i),
    .wb_wdat_i(wb_dat_i),
    .wb_cti_i (wb_cti_i),
    .wb_bte_i (wb_bte_i),
    .wb_rdat_i(wb_dat_o),
    .wb_ack_i (wb_ack_o),
    .checks_o (checks),
    .errors_o (errors)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  task automatic drive_beat(input logic we, input logic [ADR_W-1:0] adr,
                            input logic [SEL_W-1:0] sel, input logic [DAT_W-1:0] dat,
                            input cti_t cti, input bte_t bte);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_sel_i = sel;
    wb_dat_i = dat;
    wb_cti_i = cti;
    wb_bte_i = bte;
  endtask

  // returns just after the edge that completes the beat
  task automatic wait_ack();
    while (!wb_ack_o) begin
      @(posedge clk);
      #DLY;
    end
    @(posedge clk);
    #DLY;
  endtask

  task automatic release_bus();
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_cti_i = CTI_CLASSIC;
    wb_bte_i = BTE_LINEAR;
  endtask

  task automatic single_access(input logic we, input logic [ADR_W-1:0] adr,
                               input logic [SEL_W-1:0] sel, input logic [DAT_W-1:0] dat);
    drive_beat(we, adr, sel, dat, CTI_CLASSIC, BTE_LINEAR);
    wait_ack();
    release_bus();
  endtask

  task automatic burst_access(input logic we, input logic [ADR_W-1:0] start_adr,
                              input bte_t bte, input int len);
    logic [RAM_AW-1:0] word;
    logic [RAM_AW-1:0] mask;  // low word bits that step, the rest stay
    cti_t              cti;
    int                i;
    mask = (bte == BTE_LINEAR) ? '1 : RAM_AW'(len - 1);
    word = start_adr[RAM_AW+1:2];
    for (i = 0; i < len; i++) begin
      cti = (i == len - 1) ? CTI_EOB : CTI_INC;
      drive_beat(we, {start_adr[ADR_W-1:RAM_AW+2], word, 2'b00}, 4'hf, $random(seed), cti, bte);
      wait_ack();
      word = (word & ~mask) | ((word + RAM_AW'(1)) & mask);
    end
    release_bus();
  endtask

  task automatic pulse_start();
    start_i = 1'b1;
    @(posedge clk);
    #DLY;
    start_i = 1'b0;
  endtask

  task automatic wait_done();
    while (!done_o) begin
      @(posedge clk);
      #DLY;
    end
  endtask

  task automatic end_test(input string name);
    @(posedge clk);  // let the checker see the last edge
    #DLY;
    test_no++;
    if (errors == err_mark)
      $display("test %0d %s: ok", test_no, name);
    else
      $display("test %0d %s: %0d errors", test_no, name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin : stimulus
    int               i;
    logic [DAT_W-1:0] rnd;
    seed     = 73869;
    reset    = 1'b1;
    start_i  = 1'b0;
    wb_adr_i = '0;
    wb_sel_i = '0;
    wb_dat_i = '0;
    release_bus();
    repeat (3) @(posedge clk);
    #DLY;
    reset = 1'b0;
    end_test("reset values");

    pulse_start();
    wait_done();
    end_test("self-test run");

    for (i = 0; i < N_WORDS; i++)
      single_access(1'b1, 32'h400 + 4 * i, 4'hf, $random(seed));
    for (i = 0; i < N_WORDS; i++) begin
      rnd = $random(seed);
      single_access(1'b1, 32'h400 + 4 * i, rnd[3:0], $random(seed));  // random byte lanes
    end
    for (i = 0; i < N_WORDS; i++)
      single_access(1'b0, 32'h400 + 4 * i, 4'hf, '0);
    end_test("classic byte-select writes and reads");

    burst_access(1'b1, 32'h800, BTE_LINEAR, LIN_LEN);
    burst_access(1'b0, 32'h800, BTE_LINEAR, LIN_LEN);
    end_test("linear burst");

    burst_access(1'b1, 32'hc00, BTE_LINEAR, 16);
    burst_access(1'b0, 32'hc08, BTE_WRAP4, 4);  // each starts mid block
    burst_access(1'b0, 32'hc14, BTE_WRAP8, 8);
    burst_access(1'b0, 32'hc24, BTE_WRAP16, 16);
    end_test("wrapping bursts");

    pulse_start();
    @(posedge clk);  // script takes the port
    #DLY;
    single_access(1'b0, 32'h400, 4'hf, '0);
    wait_done();
    end_test("external access during self-test");

    $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* tb.f */
logic/wb_pkg.sv
logic/wb_cycle_rom.sv
logic/wb_script_master.sv
logic/wb_burst_addr.sv
logic/wb_slave_ctrl.sv
logic/wb_byte_ram.sv
logic/wb_mem_top.sv
tests/tb_checker.sv
tests/tb_top.sv

/* Makefile */
TOP := tb_top
RTL := logic/wb_pkg.sv logic/wb_cycle_rom.sv logic/wb_script_master.sv \
       logic/wb_burst_addr.sv logic/wb_slave_ctrl.sv logic/wb_byte_ram.sv logic/wb_mem_top.sv

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f $(RTL) tests/tb_checker.sv tests/tb_top.sv
	verilator --binary -j 0 -f tb.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only -Wall $(RTL) --top-module wb_mem_top

clean:
	rm -rf obj_dir
